//--- logic/sdram_params.svh
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

////////////////////////////////////////////////////////////
// sdram timing, in clock cycles
////////////////////////////////////////////////////////////

// a wait count of n holds the step for n+1 cycles
`define SDRAM_T_ACT        2    // activate to read/write, 3 cycles
`define SDRAM_T_PRE        2    // precharge to next command, 3 cycles
`define SDRAM_T_CASL       2    // read to data capture, 3 cycles
`define SDRAM_T_REF        6    // refresh to idle, 7 cycles

// auto refresh period
`define SDRAM_REF_INTERVAL 750

// banks in the device
`define SDRAM_NUM_BANKS    4

`endif

//--- logic/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    typedef logic [22:0] addr_t;     // user address, row/bank/col
    typedef logic [12:0] row_t;
    typedef logic [1:0]  bank_t;
    typedef logic [7:0]  col_t;
    typedef logic [31:0] data_t;
    typedef logic [12:0] pin_addr_t; // value on sdram_a
    typedef logic [3:0]  delay_t;

    // {cs, ras, cas, we}
    typedef enum logic [3:0] {
        CMD_UNSELECTED = 4'b1000,
        CMD_NOP        = 4'b0111,
        CMD_ACTIVE     = 4'b0011,
        CMD_READ       = 4'b0101,
        CMD_WRITE      = 4'b0100,
        CMD_PRECHARGE  = 4'b0010,
        CMD_REFRESH    = 4'b0001
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        S_INIT, S_IDLE, S_WAIT, S_REFRESH, S_ACTIVATE,
        S_READ, S_READ_RES, S_WRITE, S_PRECHARGE
    } fsm_state_e;

endpackage

`default_nettype wire

//--- logic/sdram_if.sv
`timescale 1ns/1ps
`default_nettype none

// pending request, queue to fsm
interface req_if import sdram_pkg::*; ();
    logic  pending;
    logic  rw;        // 1 = write
    addr_t addr;
    data_t wdata;
    logic  take;      // one cycle, entry empties next edge

    modport queue (output pending, rw, addr, wdata, input take);
    modport fsm   (input pending, rw, addr, wdata, output take);
endinterface

// open-row bookkeeping
interface row_if import sdram_pkg::*; ();
    bank_t bank;
    row_t  row;
    logic  open_row;
    logic  close_bank;
    logic  close_all;
    logic  bank_open;
    logic  row_hit;

    modport fsm     (output bank, row, open_row, close_bank, close_all,
                     input bank_open, row_hit);
    modport tracker (input bank, row, open_row, close_bank, close_all,
                     output bank_open, row_hit);
endinterface

// command to the pin stage
interface cmd_if import sdram_pkg::*; ();
    sdram_cmd_e cmd;
    bank_t      ba;
    pin_addr_t  a_pins;
    data_t      wdata;
    logic       drive_dq;
    logic       capture;
    data_t      rdata;

    modport fsm (output cmd, ba, a_pins, wdata, drive_dq, capture, input rdata);
    modport io  (input cmd, ba, a_pins, wdata, drive_dq, capture, output rdata);
endinterface

`default_nettype wire

//--- logic/sdram_request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_request_queue import sdram_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  logic  rw,
    input  addr_t user_addr,
    input  data_t data_in,
    output logic  busy,
    req_if.queue  req
);

    logic  full_q;
    logic  init_q;     // first cycle out of reset
    logic  rw_q;
    addr_t addr_q;
    data_t data_q;

    assign busy        = full_q;
    assign req.pending = full_q;
    assign req.rw      = rw_q;
    assign req.addr    = addr_q;
    assign req.wdata   = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b1;    // busy through reset
            init_q <= 1'b1;
        end else begin
            init_q <= 1'b0;
            if (init_q || req.take) begin
                full_q <= 1'b0;
            end else if (in_valid) begin
                full_q <= 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (!full_q && in_valid) begin
            rw_q   <= rw;
            addr_q <= user_addr;
            data_q <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/sdram_refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_ack,
    output logic refresh_due
);

    localparam int CNT_W = $clog2(`SDRAM_REF_INTERVAL);

    logic [CNT_W-1:0] cnt_q;
    logic             due_q;

    assign refresh_due = due_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
            due_q <= 1'b0;
        end else if (cnt_q == CNT_W'(`SDRAM_REF_INTERVAL - 1)) begin
            cnt_q <= '0;
            due_q <= 1'b1;     // sticky until acked
        end else begin
            cnt_q <= cnt_q + 1'b1;
            if (refresh_ack) due_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/sdram_row_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_row_tracker import sdram_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    row_if.tracker row
);

    logic [`SDRAM_NUM_BANKS-1:0] open_q;              // one flag per bank
    row_t                        row_q [`SDRAM_NUM_BANKS];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign row.bank_open = open_q[row.bank];
    assign row.row_hit   = open_q[row.bank] && (row_q[row.bank] == row.row);

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (row.close_all) begin
            open_q <= '0;                  // precharge all
        end else if (row.close_bank) begin
            open_q[row.bank] <= 1'b0;
        end else if (row.open_row) begin
            open_q[row.bank] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (row.open_row) row_q[row.bank] <= row.row;
    end

endmodule

`default_nettype wire

//--- logic/sdram_io_stage.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_io_stage import sdram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    cmd_if.io         cmd,
    output logic      sdram_cle,
    output logic      sdram_cs,
    output logic      sdram_ras,
    output logic      sdram_cas,
    output logic      sdram_we,
    output logic      sdram_dqm,
    output bank_t     sdram_ba,
    output pin_addr_t sdram_a,
    input  data_t     sdram_dqi,
    output data_t     sdram_dqo
);

    logic       cle_q;
    sdram_cmd_e cmd_q;
    bank_t      ba_q;
    pin_addr_t  a_q;
    data_t      dqo_q;
    data_t      dqi_q;
    data_t      rdata_q;

    // command word split onto the control pins
    assign sdram_cs  = cmd_q[3];
    assign sdram_ras = cmd_q[2];
    assign sdram_cas = cmd_q[1];
    assign sdram_we  = cmd_q[0];

    assign sdram_cle = cle_q;
    assign sdram_dqm = 1'b0;                            // no byte masking
    assign sdram_ba  = ba_q;
    assign sdram_a   = a_q;
    assign sdram_dqo = dqo_q;
    assign cmd.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cle_q <= 1'b0;
            cmd_q <= CMD_NOP;
            dqo_q <= '0;
        end else begin
            cle_q <= 1'b1;                              // high from 2nd cycle on
            cmd_q <= cmd.cmd;
            dqo_q <= cmd.drive_dq ? cmd.wdata : '0;     // only with WRITE
        end
    end

    always_ff @(posedge clk) begin
        ba_q  <= cmd.ba;
        a_q   <= cmd.a_pins;
        dqi_q <= sdram_dqi;                             // input flop
        if (cmd.capture) rdata_q <= dqi_q;
    end

endmodule

`default_nettype wire

//--- logic/sdram_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_fsm import sdram_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    req_if.fsm    req,
    row_if.fsm    row,
    cmd_if.fsm    cmd,
    input  logic  refresh_due,
    output logic  refresh_ack,
    output data_t data_out,
    output logic  out_valid
);

    fsm_state_e state_q;
    fsm_state_e ret_q;        // state after WAIT
    delay_t     delay_q;
    logic       pre_all_q;    // precharge all banks
    logic       rw_q;
    addr_t      addr_q;
    data_t      wdata_q;
    data_t      data_q;
    logic       out_valid_q;
    addr_t      look_addr;
    col_t       col;

    // in IDLE the tracker looks at the pending request
    assign look_addr = (state_q == S_IDLE) ? req.addr : addr_q;
    assign row.bank  = look_addr[9:8];
    assign row.row   = look_addr[22:10];
    assign col       = addr_q[7:0];

    assign refresh_ack = (state_q == S_IDLE) && refresh_due;
    assign req.take    = (state_q == S_IDLE) && !refresh_due && req.pending;
    assign data_out    = data_q;
    assign out_valid   = out_valid_q;

    ////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        cmd.cmd        = CMD_NOP;
        cmd.ba         = '0;
        cmd.a_pins     = '0;
        cmd.wdata      = wdata_q;
        cmd.drive_dq   = 1'b0;
        cmd.capture    = (state_q == S_WAIT) && (delay_q == '0) && (ret_q == S_READ_RES);
        row.open_row   = 1'b0;
        row.close_bank = 1'b0;
        row.close_all  = 1'b0;
        case (state_q)
            S_ACTIVATE: begin
                cmd.cmd      = CMD_ACTIVE;
                cmd.ba       = addr_q[9:8];
                cmd.a_pins   = addr_q[22:10];
                row.open_row = 1'b1;
            end
            S_READ: begin
                cmd.cmd    = CMD_READ;
                cmd.ba     = addr_q[9:8];
                cmd.a_pins = {3'b000, col, 2'b00};
            end
            S_WRITE: begin
                cmd.cmd      = CMD_WRITE;
                cmd.ba       = addr_q[9:8];
                cmd.a_pins   = {3'b000, col, 2'b00};
                cmd.drive_dq = 1'b1;
            end
            S_PRECHARGE: begin
                cmd.cmd        = CMD_PRECHARGE;
                cmd.ba         = pre_all_q ? bank_t'(0) : addr_q[9:8];
                cmd.a_pins[10] = pre_all_q;   // a10 selects all banks
                row.close_all  = pre_all_q;
                row.close_bank = !pre_all_q;
            end
            S_REFRESH: cmd.cmd = CMD_REFRESH;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_INIT;
            ret_q       <= S_IDLE;
            delay_q     <= '0;
            pre_all_q   <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= 1'b0;
            case (state_q)
                S_INIT: state_q <= S_IDLE;
                S_IDLE: begin
                    if (refresh_due) begin          // refresh wins over requests
                        pre_all_q <= 1'b1;
                        ret_q     <= S_REFRESH;
                        state_q   <= S_PRECHARGE;
                    end else if (req.pending) begin
                        pre_all_q <= 1'b0;
                        if (row.row_hit) begin
                            state_q <= req.rw ? S_WRITE : S_READ;
                        end else if (row.bank_open) begin   // row conflict
                            ret_q   <= S_ACTIVATE;
                            state_q <= S_PRECHARGE;
                        end else begin
                            state_q <= S_ACTIVATE;
                        end
                    end
                end
                S_WAIT: begin
                    if (delay_q == '0) state_q <= ret_q;
                    else delay_q <= delay_q - 1'b1;
                end
                S_REFRESH: begin
                    delay_q <= delay_t'(`SDRAM_T_REF);
                    ret_q   <= S_IDLE;
                    state_q <= S_WAIT;
                end
                S_ACTIVATE: begin
                    delay_q <= delay_t'(`SDRAM_T_ACT);
                    ret_q   <= rw_q ? S_WRITE : S_READ;
                    state_q <= S_WAIT;
                end
                S_READ: begin
                    delay_q <= delay_t'(`SDRAM_T_CASL);
                    ret_q   <= S_READ_RES;
                    state_q <= S_WAIT;
                end
                S_READ_RES: begin
                    out_valid_q <= 1'b1;
                    state_q     <= S_IDLE;
                end
                S_WRITE: state_q <= S_IDLE;
                S_PRECHARGE: begin
                    delay_q <= delay_t'(`SDRAM_T_PRE);
                    state_q <= S_WAIT;              // ret_q set in IDLE
                end
                default: state_q <= S_INIT;
            endcase
        end
    end

    // request copy and read data
    always_ff @(posedge clk) begin
        if (req.take) begin
            rw_q    <= req.rw;
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
        if (state_q == S_READ_RES) data_q <= cmd.rdata;
    end

endmodule

`default_nettype wire

//--- logic/sdram_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_controller import sdram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // sdram pins
    output logic      sdram_cle,
    output logic      sdram_cs,
    output logic      sdram_cas,
    output logic      sdram_ras,
    output logic      sdram_we,
    output logic      sdram_dqm,
    output bank_t     sdram_ba,
    output pin_addr_t sdram_a,
    input  data_t     sdram_dqi,
    output data_t     sdram_dqo,
    // user side
    input  addr_t     user_addr,
    input  logic      rw,         // 1 = write
    input  data_t     data_in,
    output data_t     data_out,
    output logic      busy,
    input  logic      in_valid,
    output logic      out_valid
);

    logic refresh_due;
    logic refresh_ack;

    req_if u_req ();
    row_if u_row ();
    cmd_if u_cmd ();

    sdram_request_queue i_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .rw        (rw),
        .user_addr (user_addr),
        .data_in   (data_in),
        .busy      (busy),
        .req       (u_req.queue)
    );

    sdram_refresh_timer i_refresh (
        .clk         (clk),
        .rst         (rst),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

    sdram_row_tracker i_rows (
        .clk (clk),
        .rst (rst),
        .row (u_row.tracker)
    );

    sdram_fsm i_fsm (
        .clk         (clk),
        .rst         (rst),
        .req         (u_req.fsm),
        .row         (u_row.fsm),
        .cmd         (u_cmd.fsm),
        .refresh_due (refresh_due),
        .refresh_ack (refresh_ack),
        .data_out    (data_out),
        .out_valid   (out_valid)
    );

    sdram_io_stage i_io (
        .clk       (clk),
        .rst       (rst),
        .cmd       (u_cmd.io),
        .sdram_cle (sdram_cle),
        .sdram_cs  (sdram_cs),
        .sdram_ras (sdram_ras),
        .sdram_cas (sdram_cas),
        .sdram_we  (sdram_we),
        .sdram_dqm (sdram_dqm),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .sdram_dqi (sdram_dqi),
        .sdram_dqo (sdram_dqo)
    );

endmodule

`default_nettype wire

//--- verification/sdram_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_assert import sdram_pkg::*; (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic sdram_cs,
    input logic sdram_ras,
    input logic sdram_cas,
    input logic sdram_we
);

    int         fail_count;     // failures so far
    logic [3:0] pins;
    logic       is_act;
    logic       is_pre;
    logic       is_rw;
    logic       is_cmd;

    assign pins   = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
    assign is_act = (pins == CMD_ACTIVE);
    assign is_pre = (pins == CMD_PRECHARGE);
    assign is_rw  = (pins == CMD_READ) || (pins == CMD_WRITE);
    assign is_cmd = !sdram_cs && (pins != CMD_NOP);    // deselect counts as idle

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid high on two cycles in a row");
            fail_count++;
        end

    // tRCD, three idle cycles at least
    a_act_to_rw: assert property (@(posedge clk) disable iff (rst)
        is_rw |-> !$past(is_act, 1) && !$past(is_act, 2) && !$past(is_act, 3))
        else begin
            $error("READ or WRITE less than 3 cycles after ACTIVE");
            fail_count++;
        end

    a_pre_spacing: assert property (@(posedge clk) disable iff (rst)
        is_cmd |-> !$past(is_pre, 1) && !$past(is_pre, 2) && !$past(is_pre, 3))
        else begin
            $error("command less than 3 cycles after PRECHARGE");
            fail_count++;
        end

endmodule

bind sdram_controller sdram_assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .sdram_cs  (sdram_cs),
    .sdram_ras (sdram_ras),
    .sdram_cas (sdram_cas),
    .sdram_we  (sdram_we)
);

`default_nettype wire

//--- verification/sdram_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_checker import sdram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  logic      rw,
    input  addr_t     user_addr,
    input  data_t     data_in,
    input  data_t     exp_data,
    input  logic      busy,
    input  data_t     data_out,
    input  logic      out_valid,
    input  logic      sdram_cle,
    input  logic      sdram_cs,
    input  logic      sdram_ras,
    input  logic      sdram_cas,
    input  logic      sdram_we,
    input  logic      sdram_dqm,
    input  bank_t     sdram_ba,
    input  pin_addr_t sdram_a,
    input  data_t     sdram_dqo,
    output int        err_count,
    output int        done_count,
    output int        pend_count,
    output int        ref_count
);

    typedef struct packed {
        logic  rw;
        addr_t addr;
        data_t data;
        data_t exp;
    } entry_t;

    entry_t                      pend_q [$];   // accepted, not yet executed
    entry_t                      new_e;
    logic                        head_read_sent;
    logic                        read_ok;
    logic [`SDRAM_NUM_BANKS-1:0] bank_open;
    row_t                        bank_row [`SDRAM_NUM_BANKS];
    logic                        pre_all_seen;  // since last access or refresh
    int                          ref_gap;
    int                          since_rst;
    sdram_cmd_e                  pin_cmd;

    assign pin_cmd = sdram_cmd_e'({sdram_cs, sdram_ras, sdram_cas, sdram_we});

    task automatic report_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_entry(logic ok, data_t shown);
        entry_t e;
        e = pend_q.pop_front();
        $display("entry %0d %s addr %06h data %08h: %s", done_count,
                 e.rw ? "write" : "read", e.addr, shown, ok ? "match" : "mismatch");
        done_count++;
        head_read_sent = 1'b0;
    endtask

    // READ or WRITE on the pins against the oldest request
    task automatic check_access(logic is_write);
        entry_t e;
        logic   ok;
        ok = 1'b1;
        pre_all_seen = 1'b0;
        if (pend_q.size() == 0) begin
            report_error($sformatf("%s with no request pending", is_write ? "WRITE" : "READ"));
        end else begin
            e = pend_q[0];
            if (e.rw != is_write) begin
                report_error("command type differs from the pending request");
                ok = 1'b0;
            end
            if (sdram_ba != e.addr[9:8] || sdram_a != {3'b000, e.addr[7:0], 2'b00}) begin
                report_error($sformatf("ba/a pins %0d/%h, expected %0d/%h", sdram_ba, sdram_a,
                                       e.addr[9:8], {3'b000, e.addr[7:0], 2'b00}));
                ok = 1'b0;
            end
            if (!bank_open[sdram_ba] || bank_row[sdram_ba] != e.addr[22:10]) begin
                report_error($sformatf("access to bank %0d without row %0d open",
                                       sdram_ba, e.addr[22:10]));
                ok = 1'b0;
            end
            if (is_write) begin
                if (sdram_dqo != e.data) begin
                    report_error($sformatf("sdram_dqo %08h, expected %08h", sdram_dqo, e.data));
                    ok = 1'b0;
                end
                finish_entry(ok, sdram_dqo);
            end else begin
                if (head_read_sent) report_error("second READ issued for one request");
                head_read_sent = 1'b1;
                read_ok = ok;                       // finished on out_valid
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pend_q.delete();
            head_read_sent = 1'b0;
            read_ok        = 1'b1;
            bank_open      = '0;
            pre_all_seen   = 1'b0;
            ref_gap        = 0;
            since_rst      = 0;
        end else begin
            since_rst++;

            ////////////////////////////////////////////////////////////
            // pin state
            ////////////////////////////////////////////////////////////
            if (since_rst == 1) begin
                if (sdram_cle !== 1'b0 || pin_cmd != CMD_NOP || out_valid !== 1'b0
                        || sdram_dqo != '0) begin
                    report_error("pins not idle in the first cycle after reset");
                end
            end else if (sdram_cle !== 1'b1) begin
                report_error("sdram_cle low after the first cycle");
            end
            if (sdram_dqm !== 1'b0) report_error("sdram_dqm not low");
            if (pin_cmd != CMD_WRITE && sdram_dqo != '0) report_error("sdram_dqo driven outside WRITE");

            ref_gap++;
            if (ref_gap > `SDRAM_REF_INTERVAL + 60) begin
                report_error("no REFRESH within the refresh interval");
                ref_gap = 0;
            end

            // read data ends the oldest request
            if (out_valid) begin
                if (pend_q.size() == 0 || pend_q[0].rw || !head_read_sent) begin
                    report_error("out_valid without a read in flight");
                end else begin
                    if (data_out != pend_q[0].exp) begin
                        report_error($sformatf("read %06h returned %08h, expected %08h",
                                               pend_q[0].addr, data_out, pend_q[0].exp));
                        read_ok = 1'b0;
                    end
                    finish_entry(read_ok, data_out);
                end
            end

            ////////////////////////////////////////////////////////////
            // command decode and bank model
            ////////////////////////////////////////////////////////////
            case (pin_cmd)
                CMD_NOP: ;
                CMD_ACTIVE: begin
                    if (bank_open[sdram_ba]) begin
                        report_error($sformatf("ACTIVE to bank %0d with a row open", sdram_ba));
                    end
                    if (pre_all_seen) begin
                        report_error("PRECHARGE of all banks not followed by REFRESH");
                    end
                    bank_open[sdram_ba] = 1'b1;
                    bank_row[sdram_ba]  = sdram_a;
                    pre_all_seen        = 1'b0;
                end
                CMD_PRECHARGE: begin
                    if (sdram_a[10]) begin
                        bank_open    = '0;
                        pre_all_seen = 1'b1;
                    end else begin
                        bank_open[sdram_ba] = 1'b0;
                    end
                end
                CMD_REFRESH: begin
                    if (!pre_all_seen) report_error("REFRESH without a PRECHARGE of all banks");
                    pre_all_seen = 1'b0;
                    ref_count++;
                    ref_gap = 0;
                end
                CMD_READ:  check_access(1'b0);
                CMD_WRITE: check_access(1'b1);
                default:   report_error("unknown command on the pins");
            endcase

            if (in_valid && !busy) begin            // queue takes it on this edge
                new_e.rw   = rw;
                new_e.addr = user_addr;
                new_e.data = data_in;
                new_e.exp  = exp_data;
                pend_q.push_back(new_e);
            end
        end
        pend_count = pend_q.size();
    end

endmodule

`default_nettype wire

//--- verification/sdram_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdram_params.svh"

module sdram_tb import sdram_pkg::*; ();

    localparam int NUM_TESTS       = 12;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 60 + 2 * `SDRAM_REF_INTERVAL;

    logic       clk;
    logic       rst;
    addr_t      user_addr;
    logic       rw;
    data_t      data_in;
    logic       in_valid;
    logic       busy;
    data_t      data_out;
    logic       out_valid;
    data_t      exp_data;      // expected value, travels with the request
    logic       sdram_cle;
    logic       sdram_cs;
    logic       sdram_ras;
    logic       sdram_cas;
    logic       sdram_we;
    logic       sdram_dqm;
    bank_t      sdram_ba;
    pin_addr_t  sdram_a;
    data_t      sdram_dqi;
    data_t      sdram_dqo;

    int         err_count;
    int         done_count;
    int         pend_count;
    int         ref_count;

    // stimulus table
    logic       tbl_rw   [NUM_TESTS];
    addr_t      tbl_addr [NUM_TESTS];
    data_t      tbl_data [NUM_TESTS];
    data_t      tbl_exp  [NUM_TESTS];
    integer     seed;

    // sdram memory model
    data_t      mem [addr_t];                    // key is {row, bank, col}
    row_t       model_row [`SDRAM_NUM_BANKS];
    sdram_cmd_e pin_cmd;

    assign pin_cmd = sdram_cmd_e'({sdram_cs, sdram_ras, sdram_cas, sdram_we});

    sdram_controller i_dut (
        .clk       (clk),
        .rst       (rst),
        .sdram_cle (sdram_cle),
        .sdram_cs  (sdram_cs),
        .sdram_cas (sdram_cas),
        .sdram_ras (sdram_ras),
        .sdram_we  (sdram_we),
        .sdram_dqm (sdram_dqm),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .sdram_dqi (sdram_dqi),
        .sdram_dqo (sdram_dqo),
        .user_addr (user_addr),
        .rw        (rw),
        .data_in   (data_in),
        .data_out  (data_out),
        .busy      (busy),
        .in_valid  (in_valid),
        .out_valid (out_valid)
    );

    sdram_checker i_check (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .rw         (rw),
        .user_addr  (user_addr),
        .data_in    (data_in),
        .exp_data   (exp_data),
        .busy       (busy),
        .data_out   (data_out),
        .out_valid  (out_valid),
        .sdram_cle  (sdram_cle),
        .sdram_cs   (sdram_cs),
        .sdram_ras  (sdram_ras),
        .sdram_cas  (sdram_cas),
        .sdram_we   (sdram_we),
        .sdram_dqm  (sdram_dqm),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .sdram_dqo  (sdram_dqo),
        .err_count  (err_count),
        .done_count (done_count),
        .pend_count (pend_count),
        .ref_count  (ref_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // table setup
    ////////////////////////////////////////////////////////////

    function automatic data_t unwritten_word(col_t c);
        return 32'hdead0000 + data_t'(c);
    endfunction

    task automatic set_entry(int i, logic is_write, row_t r, bank_t b, col_t c);
        tbl_rw[i]   = is_write;
        tbl_addr[i] = {r, b, c};
        tbl_data[i] = $random(seed);            // ignored by reads
    endtask

    task automatic load_table();
        set_entry(0,  1'b1, 13'd5,  2'd0, 8'd3);   // bank 0 closed
        set_entry(1,  1'b0, 13'd5,  2'd0, 8'd3);   // hit
        set_entry(2,  1'b1, 13'd5,  2'd0, 8'd9);
        set_entry(3,  1'b1, 13'd7,  2'd1, 8'd4);   // bank 1 closed
        set_entry(4,  1'b0, 13'd9,  2'd0, 8'd3);   // conflict, never written
        set_entry(5,  1'b1, 13'd9,  2'd0, 8'd3);
        set_entry(6,  1'b0, 13'd5,  2'd0, 8'd9);   // conflict back to row 5
        set_entry(7,  1'b0, 13'd7,  2'd1, 8'd4);
        set_entry(8,  1'b1, 13'd12, 2'd2, 8'd255);
        set_entry(9,  1'b1, 13'd5,  2'd0, 8'd3);   // overwrite
        set_entry(10, 1'b0, 13'd5,  2'd0, 8'd3);
        set_entry(11, 1'b0, 13'd12, 2'd2, 8'd255);
    endtask

    // a read expects the last earlier write to its address
    task automatic fill_expected();
        int i;
        int j;
        for (i = 0; i < NUM_TESTS; i++) begin
            if (tbl_rw[i]) begin
                tbl_exp[i] = tbl_data[i];
            end else begin
                tbl_exp[i] = unwritten_word(tbl_addr[i][7:0]);
                for (j = 0; j < i; j++) begin
                    if (tbl_rw[j] && tbl_addr[j] == tbl_addr[i]) tbl_exp[i] = tbl_data[j];
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        addr_t key;
        key = {model_row[sdram_ba], sdram_ba, sdram_a[9:2]};
        if (!rst) begin
            case (pin_cmd)
                CMD_ACTIVE: model_row[sdram_ba] = sdram_a;
                CMD_WRITE:  mem[key] = sdram_dqo;
                CMD_READ: begin
                    if (mem.exists(key)) sdram_dqi <= mem[key];
                    else sdram_dqi <= unwritten_word(sdram_a[9:2]);
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic issue_request(int i);
        @(posedge clk);
        while (busy) @(posedge clk);
        in_valid  <= 1'b1;
        rw        <= tbl_rw[i];
        user_addr <= tbl_addr[i];
        data_in   <= tbl_data[i];
        exp_data  <= tbl_exp[i];
        @(posedge clk);                          // captured on this edge
        in_valid  <= 1'b0;
    endtask

    task automatic wait_done(logic is_write);
        if (is_write) begin
            do begin
                @(posedge clk);
            end while (busy);
        end else begin
            do begin
                @(posedge clk);
            end while (!out_valid);
        end
    endtask

    initial begin
        int i;
        seed      = 32'h483e;
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        exp_data  = '0;
        sdram_dqi = '0;
        load_table();
        fill_expected();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < NUM_TESTS; i++) begin
            issue_request(i);
            wait_done(tbl_rw[i]);
        end
        // two refresh rounds, the last write drains meanwhile
        while (ref_count < 2) @(posedge clk);
        repeat (4) @(posedge clk);
        if (pend_count != 0) $display("%0d accepted requests never executed", pend_count);
        if (done_count != NUM_TESTS) begin
            $display("only %0d of %0d table entries completed", done_count, NUM_TESTS);
        end
        if (i_dut.i_assert.fail_count != 0) begin
            $display("protocol assertions failed %0d times", i_dut.i_assert.fail_count);
        end
        $display("entries %0d, errors %0d, refreshes %0d, assertion failures %0d",
                 done_count, err_count, ref_count, i_dut.i_assert.fail_count);
        if (err_count == 0 && pend_count == 0 && done_count == NUM_TESTS
                && i_dut.i_assert.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (8 + WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/sdram_pkg.sv
logic/sdram_if.sv
logic/sdram_request_queue.sv
logic/sdram_refresh_timer.sv
logic/sdram_row_tracker.sv
logic/sdram_io_stage.sv
logic/sdram_fsm.sv
logic/sdram_controller.sv
verification/sdram_assert.sv
verification/sdram_checker.sv
verification/sdram_tb.sv

//--- run.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module sdram_tb -f files.f -o sim_sdram

./obj_dir/sim_sdram +verilator+error+limit+100 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
